// File: buffer/capture_bank_router.sv
// capture control, interleaved channel to bank mapping, write steering and full detection
`include "buffer_cfg.svh"

module capture_bank_router (
  input  logic                    capture_clk,
  input  logic                    readout_reset,
  input  buffer_pkg::capture_in_t capture_in,
  input  buffer_pkg::active_sel_t active_sel,
  input  logic                    capture_start,
  input  logic                    capture_stop,
  input  logic                    capture_sw_reset,
  input  buffer_pkg::depth_vec_t  bank_depth,
  output buffer_pkg::bank_wr_t    bank_wr,
  output logic                    bank_clear,
  output logic                    capturing,
  output logic                    capture_full
);

  localparam int CH = `BUF_CHANNELS;
  localparam int BANK_W = $clog2(`BUF_CHANNELS);

  buffer_pkg::active_sel_t active_q;
  int active_cnt;
  logic [BANK_W-1:0] cur_bank [CH];
  // per channel flags for a write now, a bank fill and the last bank
  logic [CH-1:0] ch_wr;
  logic [CH-1:0] ch_fill;
  logic [CH-1:0] ch_last;
  // hits[bank][channel]
  logic [CH-1:0][CH-1:0] hits;
  logic start_idle;
  logic full_hit;

  // mode is latched when a capture arms so the mapping holds for the whole run
  always_comb begin
    case (active_q)
      2'd0: active_cnt = 1;
      2'd1: active_cnt = 2;
      default: active_cnt = 4;
    endcase
  end

  assign start_idle = capture_start && !capturing;
  assign bank_clear = capture_sw_reset || start_idle;

  //////////////////////////////////////////////////
  // per channel write decisions
  //////////////////////////////////////////////////

  always_comb begin
    for (int ch = 0; ch < CH; ch++) begin
      // nothing lands on the stop or reset edge
      ch_wr[ch] = capturing && !capture_stop && !capture_sw_reset &&
                  (ch < active_cnt) && capture_in.valid[ch];
      ch_fill[ch] = ch_wr[ch] &&
                    (bank_depth[cur_bank[ch]] == buffer_pkg::depth_t'(`BUF_DEPTH - 1));
      ch_last[ch] = (int'(cur_bank[ch]) + active_cnt) >= CH;
    end
  end

  // steer each channel onto its current bank
  always_comb begin
    for (int b = 0; b < CH; b++) begin
      bank_wr.wr_en[b] = 1'b0;
      bank_wr.data[b] = capture_in.data[b];
      for (int ch = 0; ch < CH; ch++) begin
        hits[b][ch] = ch_wr[ch] && (int'(cur_bank[ch]) == b);
        if (hits[b][ch]) begin
          bank_wr.wr_en[b] = 1'b1;
          bank_wr.data[b] = capture_in.data[ch];
        end
      end
    end
  end

  // a channel filling its final bank ends the capture
  assign full_hit = |(ch_fill & ch_last);

  //////////////////////////////////////////////////
  // capture state
  //////////////////////////////////////////////////

  always_ff @(posedge capture_clk) begin
    if (readout_reset || capture_sw_reset) begin
      capturing <= 1'b0;
      capture_full <= 1'b0;
    end else if (start_idle) begin
      capturing <= 1'b1;
      capture_full <= 1'b0;
    end else if (capture_stop) begin
      capturing <= 1'b0;
    end else if (full_hit) begin
      capturing <= 1'b0;
      capture_full <= 1'b1;
    end
  end

  always_ff @(posedge capture_clk) begin
    if (readout_reset) begin
      active_q <= '0;
    end else if (start_idle) begin
      active_q <= active_sel;
    end
  end

  // channel ch starts on bank ch and steps by the active count
  always_ff @(posedge capture_clk) begin
    for (int ch = 0; ch < CH; ch++) begin
      if (readout_reset || bank_clear) begin
        cur_bank[ch] <= BANK_W'(ch);
      end else if (ch_fill[ch] && !ch_last[ch]) begin
        cur_bank[ch] <= BANK_W'(int'(cur_bank[ch]) + active_cnt);
      end
    end
  end

  // interleaving keeps every bank owned by at most one channel
  for (genvar b = 0; b < CH; b++) begin : g_one_writer
    assert property (@(posedge capture_clk) disable iff (readout_reset)
      $onehot0(hits[b]));
  end

endmodule

// File: buffer/readout_sequencer.sv
// walks every bank and address in order and streams the words out with valid/ready
`include "buffer_cfg.svh"

module readout_sequencer (
  input  logic                                    capture_clk,
  input  logic                                    readout_reset,
  input  logic                                    readout_start,
  input  logic                                    readout_sw_reset,
  input  logic                                    capturing,
  input  buffer_pkg::sample_t [`BUF_CHANNELS-1:0] rd_data,
  output logic [$clog2(`BUF_DEPTH)-1:0]           rd_addr,
  input  logic                                    readout_ready,
  output logic                                    readout_valid,
  output buffer_pkg::readout_beat_t               readout_beat
);

  localparam int CH = `BUF_CHANNELS;
  localparam int ADDR_W = $clog2(`BUF_DEPTH);
  localparam int BANK_W = $clog2(`BUF_CHANNELS);

  logic busy;
  // stream finished and waiting for readout_start to drop
  logic done;
  logic [BANK_W-1:0] bank_sel;
  logic [ADDR_W-1:0] addr;
  logic final_word;
  logic issue;
  logic go;

  // read issued last cycle whose data arrives this cycle
  logic inflight;
  logic [BANK_W-1:0] sel_q;
  logic last_q;

  // two-entry output buffer
  buffer_pkg::readout_beat_t buf_mem [2];
  logic wr_ptr;
  logic rd_ptr;
  logic [1:0] count;
  logic pop;
  logic [2:0] pending;

  assign pop = readout_valid && readout_ready;
  // entries held after this edge including the read that lands now
  assign pending = {1'b0, count} + {2'b00, inflight} - {2'b00, pop};
  assign issue = busy && (pending < 3'd2);
  assign final_word = (bank_sel == BANK_W'(CH - 1)) &&
                      (addr == ADDR_W'(`BUF_DEPTH - 1));
  assign go = readout_start && !busy && !done && !capturing &&
              (count == 2'd0) && !inflight;
  assign rd_addr = addr;

  //////////////////////////////////////////////////
  // bank and address walk
  //////////////////////////////////////////////////

  always_ff @(posedge capture_clk) begin
    if (readout_reset || readout_sw_reset) begin
      busy <= 1'b0;
      done <= 1'b0;
      bank_sel <= '0;
      addr <= '0;
    end else if (go) begin
      busy <= 1'b1;
      bank_sel <= '0;
      addr <= '0;
    end else if (issue) begin
      if (final_word) begin
        busy <= 1'b0;
        done <= 1'b1;
      end else if (addr == ADDR_W'(`BUF_DEPTH - 1)) begin
        addr <= '0;
        bank_sel <= bank_sel + 1'b1;
      end else begin
        addr <= addr + 1'b1;
      end
    end else if (done && !readout_start) begin
      done <= 1'b0;
    end
  end

  // bank read is one cycle deep
  always_ff @(posedge capture_clk) begin
    if (readout_reset || readout_sw_reset) begin
      inflight <= 1'b0;
    end else begin
      inflight <= issue;
    end
  end

  always_ff @(posedge capture_clk) begin
    if (issue) begin
      sel_q <= bank_sel;
      last_q <= final_word;
    end
  end

  //////////////////////////////////////////////////
  // output buffer
  //////////////////////////////////////////////////

  always_ff @(posedge capture_clk) begin
    if (readout_reset || readout_sw_reset) begin
      count <= 2'd0;
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
    end else begin
      if (inflight) begin
        wr_ptr <= !wr_ptr;
      end
      if (pop) begin
        rd_ptr <= !rd_ptr;
      end
      count <= count + {1'b0, inflight} - {1'b0, pop};
    end
  end

  // mux the selected bank as its data arrives
  always_ff @(posedge capture_clk) begin
    if (inflight) begin
      buf_mem[wr_ptr].data <= rd_data[sel_q];
      buf_mem[wr_ptr].last <= last_q;
    end
  end

  assign readout_valid = (count != 2'd0);
  assign readout_beat = buf_mem[rd_ptr];

  // a stalled beat holds until the consumer takes it
  assert property (@(posedge capture_clk) disable iff (readout_reset || readout_sw_reset)
    readout_valid && !readout_ready |=> readout_valid && $stable(readout_beat));

endmodule

// File: buffer/sample_bank.sv
// one capture bank with registered read data and a write pointer that doubles as its depth
`include "buffer_cfg.svh"

module sample_bank (
  input  logic                          capture_clk,
  input  logic                          readout_reset,
  input  logic                          clear,
  input  logic                          wr_en,
  input  buffer_pkg::sample_t           wr_data,
  input  logic [$clog2(`BUF_DEPTH)-1:0] rd_addr,
  output buffer_pkg::sample_t           rd_data,
  output buffer_pkg::depth_t            depth
);

  localparam int ADDR_W = $clog2(`BUF_DEPTH);

  buffer_pkg::sample_t mem [`BUF_DEPTH];
  logic bank_full;
  logic do_write;

  assign bank_full = (depth == buffer_pkg::depth_t'(`BUF_DEPTH));
  // writes into a full bank are dropped
  assign do_write = wr_en && !bank_full && !clear;

  // write pointer, reported as the bank depth
  always_ff @(posedge capture_clk) begin
    if (readout_reset || clear) begin
      depth <= '0;
    end else if (do_write) begin
      depth <= depth + 1'b1;
    end
  end

  always_ff @(posedge capture_clk) begin
    if (do_write) begin
      mem[depth[ADDR_W-1:0]] <= wr_data;
    end
    rd_data <= mem[rd_addr];
  end

  // the router must move a channel on to its next bank once this one fills
  assert property (@(posedge capture_clk) disable iff (readout_reset)
    !(wr_en && bank_full));

endmodule

// File: common/buffer_cfg.svh
// channel count, bank depth and sample width shared by the package and every RTL file
`ifndef BUFFER_CFG_SVH
`define BUFFER_CFG_SVH

//////////////////////////////////////////////////
// buffer geometry
//////////////////////////////////////////////////

// number of input channels, which is also the number of banks
`define BUF_CHANNELS 4

// words held by each bank
`define BUF_DEPTH 16

//////////////////////////////////////////////////
// sample format
//////////////////////////////////////////////////

`define BUF_DATA_WIDTH 16

`endif

// File: common/buffer_pkg.sv
// types for samples, bank writes, depth counts and readout beats used across the capture buffer
`include "buffer_cfg.svh"

package buffer_pkg;

  //////////////////////////////////////////////////
  // capture side
  //////////////////////////////////////////////////

  typedef logic [`BUF_DATA_WIDTH-1:0] sample_t;

  // 0 selects 1 active channel, 1 selects 2, 2 selects 4
  typedef logic [1:0] active_sel_t;

  // one strobe and one sample per channel
  typedef struct packed {
    logic [`BUF_CHANNELS-1:0]    valid;
    sample_t [`BUF_CHANNELS-1:0] data;
  } capture_in_t;

  // write count of a bank from 0 up to and including BUF_DEPTH
  typedef logic [$clog2(`BUF_DEPTH):0] depth_t;

  typedef depth_t [`BUF_CHANNELS-1:0] depth_vec_t;

  // steered writes with one lane per bank
  typedef struct packed {
    logic [`BUF_CHANNELS-1:0]    wr_en;
    sample_t [`BUF_CHANNELS-1:0] data;
  } bank_wr_t;

  //////////////////////////////////////////////////
  // readout side
  //////////////////////////////////////////////////

  typedef struct packed {
    sample_t data;
    logic    last;
  } readout_beat_t;

endpackage

// File: compile.f
+incdir+common
common/buffer_pkg.sv
buffer/sample_bank.sv
buffer/capture_bank_router.sv
buffer/readout_sequencer.sv
verilog/capture_buffer_top.sv
tb/capture_buffer_checker.sv
tb/capture_buffer_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the capture buffer testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  -f compile.f --top-module capture_buffer_tb --Mdir obj_dir -o capture_buffer_sim \
  && ./obj_dir/capture_buffer_sim | tee /dev/stderr | grep -qx "TEST PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: tb/capture_buffer_checker.sv
// reference model of the capture buffer that compares depths, full flag and readout stream each clock
`include "buffer_cfg.svh"

module capture_buffer_checker (
  input  logic                      capture_clk,
  input  logic                      readout_reset,
  input  buffer_pkg::capture_in_t   capture_in,
  input  buffer_pkg::active_sel_t   active_sel,
  input  logic                      capture_start,
  input  logic                      capture_stop,
  input  logic                      capture_sw_reset,
  input  logic                      readout_start,
  input  logic                      readout_sw_reset,
  input  logic                      readout_ready,
  input  logic                      capture_full,
  input  buffer_pkg::depth_vec_t    capture_write_depth,
  input  logic                      readout_valid,
  input  buffer_pkg::readout_beat_t readout_beat,
  output int                        errors,
  output int                        checks,
  output int                        streams_done
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CH = `BUF_CHANNELS;
  localparam int DEPTH = `BUF_DEPTH;
  localparam int WORDS = CH * DEPTH;

  // samples accepted per channel in arrival order
  buffer_pkg::sample_t sent [CH][WORDS];
  int sent_cnt [CH];
  int active;
  logic capturing;
  logic full;
  int beat_idx;
  // a requested stream is running
  logic rd_open;
  // last beat taken and readout_start not yet dropped
  logic rd_finished;

  initial begin
    errors = 0;
    checks = 0;
    streams_done = 0;
    active = 1;
    capturing = 1'b0;
    full = 1'b0;
    beat_idx = 0;
    rd_open = 1'b0;
    rd_finished = 1'b0;
  end

  function automatic int active_count(input buffer_pkg::active_sel_t code);
    case (code)
      2'd0: return 1;
      2'd1: return 2;
      default: return 4;
    endcase
  endfunction

  // bank b holds words k*DEPTH up to (k+1)*DEPTH of channel b mod active
  function automatic int expected_depth(input int b);
    int n;
    n = sent_cnt[b % active] - (b / active) * DEPTH;
    if (n < 0) begin
      n = 0;
    end else if (n > DEPTH) begin
      n = DEPTH;
    end
    return n;
  endfunction

  function automatic void clear_model();
    for (int c = 0; c < CH; c++) begin
      sent_cnt[c] = 0;
    end
  endfunction

  //////////////////////////////////////////////////
  // capture side
  //////////////////////////////////////////////////

  task automatic check_capture();
    checks++;
    if (capture_full !== full) begin
      $display("Error at %0d ns: capture_full expected %b, got %b", $time, full, capture_full);
      errors++;
    end
    for (int b = 0; b < CH; b++) begin
      checks++;
      if (capture_write_depth[b] !== buffer_pkg::depth_t'(expected_depth(b))) begin
        $display("Error at %0d ns: capture_write_depth[%0d] expected %0d, got %0d",
                 $time, b, expected_depth(b), capture_write_depth[b]);
        errors++;
      end
    end
  endtask

  task automatic update_model();
    int cap;
    cap = DEPTH * (CH / active);
    if (capture_sw_reset) begin
      clear_model();
      capturing = 1'b0;
      full = 1'b0;
    end else if (capture_start && !capturing) begin
      clear_model();
      capturing = 1'b1;
      full = 1'b0;
      active = active_count(active_sel);
    end else if (capture_stop) begin
      capturing = 1'b0;
    end else if (capturing) begin
      for (int c = 0; c < active; c++) begin
        if (capture_in.valid[c] && sent_cnt[c] < cap) begin
          sent[c][sent_cnt[c]] = capture_in.data[c];
          sent_cnt[c]++;
        end
      end
      // one channel at capacity ends the run for everyone
      for (int c = 0; c < active; c++) begin
        if (sent_cnt[c] == cap) begin
          capturing = 1'b0;
          full = 1'b1;
        end
      end
    end
  endtask

  //////////////////////////////////////////////////
  // readout side
  //////////////////////////////////////////////////

  task automatic check_readout();
    int bank;
    int addr;
    int word;
    logic exp_last;
    if (readout_sw_reset) begin
      beat_idx = 0;
      rd_open = 1'b0;
      rd_finished = 1'b0;
    end else begin
      if (!rd_open) begin
        // no beat may show outside a requested stream
        checks++;
        if (readout_valid !== 1'b0) begin
          $display("Error at %0d ns: readout_valid expected 0, got %b", $time, readout_valid);
          errors++;
        end
      end else if (readout_valid === 1'b1 && readout_ready === 1'b1) begin
        bank = beat_idx / DEPTH;
        addr = beat_idx % DEPTH;
        word = (bank / active) * DEPTH + addr;
        exp_last = (beat_idx == WORDS - 1);
        checks++;
        if (readout_beat.last !== exp_last) begin
          $display("Error at %0d ns: readout_beat.last (beat %0d) expected %b, got %b",
                   $time, beat_idx, exp_last, readout_beat.last);
          errors++;
        end
        // words past a bank's depth were never written
        if (addr < expected_depth(bank)) begin
          checks++;
          if (readout_beat.data !== sent[bank % active][word]) begin
            $display("Error at %0d ns: readout_beat.data (beat %0d) expected %h, got %h",
                     $time, beat_idx, sent[bank % active][word], readout_beat.data);
            errors++;
          end
        end
        if (exp_last) begin
          beat_idx = 0;
          streams_done++;
          rd_open = 1'b0;
          rd_finished = 1'b1;
        end else begin
          beat_idx++;
        end
      end
      // a finished stream opens again only after readout_start drops
      if (rd_finished) begin
        rd_finished = readout_start;
      end else if (readout_start && !rd_open && !capturing) begin
        rd_open = 1'b1;
      end
    end
  endtask

  always @(posedge capture_clk) begin
    if (readout_reset) begin
      clear_model();
      capturing = 1'b0;
      full = 1'b0;
      active = 1;
      beat_idx = 0;
      rd_open = 1'b0;
      rd_finished = 1'b0;
    end else begin
      check_capture();
      check_readout();
      update_model();
    end
  end

endmodule

// File: tb/capture_buffer_tb.sv
// testbench top for the capture buffer that drives random samples and runs the capture and readout tests
`include "buffer_cfg.svh"

module capture_buffer_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CH = `BUF_CHANNELS;
  localparam int WORDS = `BUF_CHANNELS * `BUF_DEPTH;
  // worst case cycles for one capture and for one readout under random ready
  localparam int CAPTURE_LIMIT = 8 * WORDS;
  localparam int READOUT_LIMIT = 8 * WORDS;
  localparam int RUNS = 11;
  localparam int WATCHDOG_CYCLES = RUNS * (CAPTURE_LIMIT + READOUT_LIMIT) * 4;

  logic capture_clk;
  logic readout_reset;
  buffer_pkg::capture_in_t capture_in;
  buffer_pkg::active_sel_t active_sel;
  logic capture_start;
  logic capture_stop;
  logic capture_sw_reset;
  logic readout_start;
  logic readout_sw_reset;
  logic readout_ready;
  logic capture_full;
  buffer_pkg::depth_vec_t capture_write_depth;
  logic readout_valid;
  buffer_pkg::readout_beat_t readout_beat;

  logic hold_ready;
  int timeouts;
  int errors;
  int checks;
  int streams_done;

  capture_buffer_top UUT (
    .capture_clk         (capture_clk),
    .readout_reset       (readout_reset),
    .capture_in          (capture_in),
    .active_sel          (active_sel),
    .capture_start       (capture_start),
    .capture_stop        (capture_stop),
    .capture_sw_reset    (capture_sw_reset),
    .readout_start       (readout_start),
    .readout_sw_reset    (readout_sw_reset),
    .readout_ready       (readout_ready),
    .capture_full        (capture_full),
    .capture_write_depth (capture_write_depth),
    .readout_valid       (readout_valid),
    .readout_beat        (readout_beat)
  );

  capture_buffer_checker scoreboard (
    .capture_clk         (capture_clk),
    .readout_reset       (readout_reset),
    .capture_in          (capture_in),
    .active_sel          (active_sel),
    .capture_start       (capture_start),
    .capture_stop        (capture_stop),
    .capture_sw_reset    (capture_sw_reset),
    .readout_start       (readout_start),
    .readout_sw_reset    (readout_sw_reset),
    .readout_ready       (readout_ready),
    .capture_full        (capture_full),
    .capture_write_depth (capture_write_depth),
    .readout_valid       (readout_valid),
    .readout_beat        (readout_beat),
    .errors              (errors),
    .checks              (checks),
    .streams_done        (streams_done)
  );

  always #10 capture_clk = ~capture_clk;

  // fresh samples and a random ready on every falling edge
  always @(negedge capture_clk) begin
    capture_in.valid = CH'($urandom);
    for (int c = 0; c < CH; c++) begin
      capture_in.data[c] = buffer_pkg::sample_t'($urandom);
    end
    readout_ready = 1'($urandom_range(0, 1)) && !hold_ready;
  end

  //////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge capture_clk);
  endtask

  task automatic start_capture(input buffer_pkg::active_sel_t code);
    @(negedge capture_clk);
    active_sel = code;
    capture_start = 1'b1;
    @(negedge capture_clk);
    capture_start = 1'b0;
  endtask

  task automatic stop_capture();
    @(negedge capture_clk);
    capture_stop = 1'b1;
    @(negedge capture_clk);
    capture_stop = 1'b0;
  endtask

  task automatic reset_capture();
    @(negedge capture_clk);
    capture_sw_reset = 1'b1;
    @(negedge capture_clk);
    capture_sw_reset = 1'b0;
  endtask

  task automatic wait_full();
    int n;
    n = 0;
    while (capture_full !== 1'b1 && n < CAPTURE_LIMIT) begin
      @(negedge capture_clk);
      n++;
    end
    if (capture_full !== 1'b1) begin
      $display("capture_full did not rise within %0d cycles", CAPTURE_LIMIT);
      timeouts++;
    end
  endtask

  // hold readout_start until the final beat has been taken
  task automatic run_readout();
    int done_before;
    int n;
    done_before = streams_done;
    n = 0;
    @(negedge capture_clk);
    readout_start = 1'b1;
    while (streams_done == done_before && n < READOUT_LIMIT) begin
      @(negedge capture_clk);
      n++;
    end
    readout_start = 1'b0;
    if (streams_done == done_before) begin
      $display("readout stream did not finish within %0d cycles", READOUT_LIMIT);
      timeouts++;
    end
  endtask

  // abort a stream partway with ready held low across the reset edge
  task automatic abort_readout(input int cycles);
    @(negedge capture_clk);
    readout_start = 1'b1;
    idle_cycles(cycles);
    @(posedge capture_clk);
    hold_ready = 1'b1;
    @(negedge capture_clk);
    readout_start = 1'b0;
    readout_sw_reset = 1'b1;
    @(negedge capture_clk);
    readout_sw_reset = 1'b0;
    @(posedge capture_clk);
    hold_ready = 1'b0;
  endtask

  task automatic report(input logic timed_out);
    $display("errors %0d, timeouts %0d, checks %0d", errors, timeouts + int'(timed_out), checks);
    if (!timed_out && errors == 0 && timeouts == 0 && checks > 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(13));
    capture_clk = 1'b0;
    readout_reset = 1'b1;
    capture_in = '0;
    active_sel = '0;
    capture_start = 1'b0;
    capture_stop = 1'b0;
    capture_sw_reset = 1'b0;
    readout_start = 1'b0;
    readout_sw_reset = 1'b0;
    readout_ready = 1'b0;
    hold_ready = 1'b0;
    timeouts = 0;
    repeat (3) @(posedge capture_clk);
    @(negedge capture_clk);
    readout_reset = 1'b0;

    for (int code = 0; code < 3; code++) begin
      // partial capture
      start_capture(buffer_pkg::active_sel_t'(code));
      idle_cycles(20 - 4 * code);
      stop_capture();
      run_readout();
      // capture until a channel runs out of banks
      start_capture(buffer_pkg::active_sel_t'(code));
      wait_full();
      idle_cycles(3);
      run_readout();
    end

    // stop without a start leaves every bank empty
    reset_capture();
    stop_capture();
    run_readout();

    // software reset partway through a capture
    start_capture(2'd1);
    idle_cycles(10);
    reset_capture();
    idle_cycles(2);
    start_capture(2'd2);
    idle_cycles(14);
    stop_capture();
    run_readout();

    abort_readout(30);
    run_readout();

    idle_cycles(4);
    report(1'b0);
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge capture_clk);
    $display("watchdog ended the run after %0d cycles", WATCHDOG_CYCLES);
    report(1'b1);
  end

endmodule

// File: verilog/capture_buffer_top.sv
// top level of the banked capture buffer joining the router, the banks and the readout sequencer
`include "buffer_cfg.svh"

module capture_buffer_top (
  input  logic                      capture_clk,
  input  logic                      readout_reset,
  input  buffer_pkg::capture_in_t   capture_in,
  input  buffer_pkg::active_sel_t   active_sel,
  input  logic                      capture_start,
  input  logic                      capture_stop,
  input  logic                      capture_sw_reset,
  input  logic                      readout_start,
  input  logic                      readout_sw_reset,
  input  logic                      readout_ready,
  output logic                      capture_full,
  output buffer_pkg::depth_vec_t    capture_write_depth,
  output logic                      readout_valid,
  output buffer_pkg::readout_beat_t readout_beat
);

  buffer_pkg::bank_wr_t bank_wr;
  logic bank_clear;
  logic capturing;
  buffer_pkg::sample_t [`BUF_CHANNELS-1:0] rd_data;
  logic [$clog2(`BUF_DEPTH)-1:0] rd_addr;

  //////////////////////////////////////////////////
  // capture side
  //////////////////////////////////////////////////

  capture_bank_router router_i (
    .capture_clk      (capture_clk),
    .readout_reset    (readout_reset),
    .capture_in       (capture_in),
    .active_sel       (active_sel),
    .capture_start    (capture_start),
    .capture_stop     (capture_stop),
    .capture_sw_reset (capture_sw_reset),
    .bank_depth       (capture_write_depth),
    .bank_wr          (bank_wr),
    .bank_clear       (bank_clear),
    .capturing        (capturing),
    .capture_full     (capture_full)
  );

  // one bank per channel with all banks on the shared read address
  for (genvar b = 0; b < `BUF_CHANNELS; b++) begin : g_bank
    sample_bank bank_i (
      .capture_clk   (capture_clk),
      .readout_reset (readout_reset),
      .clear         (bank_clear),
      .wr_en         (bank_wr.wr_en[b]),
      .wr_data       (bank_wr.data[b]),
      .rd_addr       (rd_addr),
      .rd_data       (rd_data[b]),
      .depth         (capture_write_depth[b])
    );
  end

  //////////////////////////////////////////////////
  // readout side
  //////////////////////////////////////////////////

  readout_sequencer sequencer_i (
    .capture_clk      (capture_clk),
    .readout_reset    (readout_reset),
    .readout_start    (readout_start),
    .readout_sw_reset (readout_sw_reset),
    .capturing        (capturing),
    .rd_data          (rd_data),
    .rd_addr          (rd_addr),
    .readout_ready    (readout_ready),
    .readout_valid    (readout_valid),
    .readout_beat     (readout_beat)
  );

endmodule
